// ==== bus_pkg.sv ====
package bus_pkg;

  // --------------------
  // bus widths
  // --------------------
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;
  localparam int BYTE_OFS_W = $clog2(STRB_W);  // byte lane bits below the word index

  // --------------------
  // address map
  // --------------------
  localparam int RAM_WORDS = 1024;
  localparam int RAM_BYTES = RAM_WORDS * STRB_W;  // ram sits at 0 .. RAM_BYTES-1
  localparam int WORD_IDX_W = $clog2(RAM_WORDS);
  localparam logic [ADDR_W-1:0] EXIT_ADDR = 32'h1000_0000;  // simulation exit register

  // response codes as on the AXI4-Lite B and R channels
  localparam logic [1:0] RESP_OKAY = 2'd0;
  localparam logic [1:0] RESP_SLVERR = 2'd2;  // no target here reports it
  localparam logic [1:0] RESP_DECERR = 2'd3;

  // port 0 is the data master, port 1 the instruction master
  localparam int NUM_PORTS = 2;

  // --------------------
  // internal transfer types
  // --------------------
  typedef struct packed {
    logic              write;  // 1 for AW/W, 0 for AR
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
  } bus_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;  // don't care on writes
    logic [1:0]        resp;
  } bus_rsp_t;

endpackage

// ==== axil_port.sv ====
`timescale 1ns/100ps

module axil_port (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic [bus_pkg::ADDR_W-1:0] awaddr_i,
  input  logic                       awvalid_i,
  output logic                       awready_o,
  input  logic [bus_pkg::DATA_W-1:0] wdata_i,
  input  logic [bus_pkg::STRB_W-1:0] wstrb_i,
  input  logic                       wvalid_i,
  output logic                       wready_o,
  output logic [1:0]                 bresp_o,
  output logic                       bvalid_o,
  input  logic                       bready_i,
  input  logic [bus_pkg::ADDR_W-1:0] araddr_i,
  input  logic                       arvalid_i,
  output logic                       arready_o,
  output logic [bus_pkg::DATA_W-1:0] rdata_o,
  output logic [1:0]                 rresp_o,
  output logic                       rvalid_o,
  input  logic                       rready_i,
  output logic                       req_valid_o,
  output bus_pkg::bus_req_t          req_o,
  input  logic                       rsp_valid_i,
  input  bus_pkg::bus_rsp_t          rsp_i
);
  import bus_pkg::*;

  logic     aw_held_q;
  logic     w_held_q;
  logic     req_valid_q;
  logic     bvalid_q;
  logic     rvalid_q;
  bus_req_t req_q;
  bus_rsp_t rsp_q;
  logic     idle;
  logic     aw_hs;
  logic     w_hs;
  logic     ar_hs;
  logic     aw_done;
  logic     w_done;

  // --------------------
  // channel handshakes
  // --------------------
  assign idle = !req_valid_q && !bvalid_q && !rvalid_q;  // nothing in flight, no response held
  assign awready_o = idle && !aw_held_q;
  assign wready_o = idle && !w_held_q;
  // a write that has started or is being offered goes before a read
  assign arready_o = idle && !aw_held_q && !w_held_q && !awvalid_i && !wvalid_i;

  assign aw_hs = awvalid_i && awready_o;
  assign w_hs = wvalid_i && wready_o;
  assign ar_hs = arvalid_i && arready_o;
  assign aw_done = aw_held_q || aw_hs;
  assign w_done = w_held_q || w_hs;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      aw_held_q <= 1'b0;
      w_held_q <= 1'b0;
      req_valid_q <= 1'b0;
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (aw_done && w_done) begin
        aw_held_q <= 1'b0;
        w_held_q <= 1'b0;
        req_valid_q <= 1'b1;  // write request complete
      end else begin
        aw_held_q <= aw_done;
        w_held_q <= w_done;
        if (ar_hs) begin
          req_valid_q <= 1'b1;
        end
      end
      if (rsp_valid_i) begin
        req_valid_q <= 1'b0;
        bvalid_q <= req_q.write;  // route to B or R
        rvalid_q <= !req_q.write;
      end
      if (bvalid_q && bready_i) begin
        bvalid_q <= 1'b0;
      end
      if (rvalid_q && rready_i) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // request and response payload
  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      req_q.addr <= awaddr_i;
      req_q.write <= 1'b1;
    end
    if (w_hs) begin
      req_q.wdata <= wdata_i;
      req_q.wstrb <= wstrb_i;
    end
    if (ar_hs) begin
      req_q.addr <= araddr_i;
      req_q.write <= 1'b0;
      req_q.wdata <= '0;
      req_q.wstrb <= '0;
    end
    if (rsp_valid_i) begin
      rsp_q <= rsp_i;  // held until the master takes it
    end
  end

  assign req_valid_o = req_valid_q;
  assign req_o = req_q;
  assign bvalid_o = bvalid_q;
  assign bresp_o = rsp_q.resp;
  assign rvalid_o = rvalid_q;
  assign rdata_o = rsp_q.rdata;
  assign rresp_o = rsp_q.resp;

  // the arbiter only answers a request this port is still waiting on
  a_rsp_has_req : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rsp_valid_i |-> req_valid_q)
    else $error("response without outstanding request");

endmodule

// ==== bus_arbiter.sv ====
`timescale 1ns/100ps

module bus_arbiter (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic [bus_pkg::NUM_PORTS-1:0] req_valid_i,
  input  bus_pkg::bus_req_t             req_i [bus_pkg::NUM_PORTS],
  output logic [bus_pkg::NUM_PORTS-1:0] rsp_valid_o,
  output bus_pkg::bus_rsp_t             rsp_o [bus_pkg::NUM_PORTS],
  output logic                          ram_req_valid_o,
  output logic                          exit_req_valid_o,
  output bus_pkg::bus_req_t             tgt_req_o,
  input  logic                          ram_rsp_valid_i,
  input  bus_pkg::bus_rsp_t             ram_rsp_i,
  input  logic                          exit_rsp_valid_i,
  input  bus_pkg::bus_rsp_t             exit_rsp_i
);
  import bus_pkg::*;

  logic     busy_q;    // a request is with a target
  logic     last_q;    // port granted last, also the port being served
  logic     decerr_q;  // unmapped access, answer locally
  logic     pick;
  logic     grant;
  logic     hit_ram;
  logic     hit_exit;
  logic     any_rsp;
  bus_rsp_t sel_rsp;

  // --------------------
  // round robin grant
  // --------------------
  always_comb begin
    if (&req_valid_i) begin
      pick = ~last_q;  // both pending, loser of last round goes
    end else begin
      pick = req_valid_i[1];
    end
  end

  assign grant = !busy_q && |req_valid_i;
  assign tgt_req_o = req_i[pick];

  // address decode
  assign hit_ram = tgt_req_o.addr < ADDR_W'(RAM_BYTES);
  assign hit_exit = tgt_req_o.addr == EXIT_ADDR;
  assign ram_req_valid_o = grant && hit_ram;
  assign exit_req_valid_o = grant && hit_exit;

  assign any_rsp = ram_rsp_valid_i || exit_rsp_valid_i || decerr_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q <= 1'b0;
      last_q <= 1'b1;  // data port wins the first tie
      decerr_q <= 1'b0;
    end else if (grant) begin
      busy_q <= 1'b1;
      last_q <= pick;
      decerr_q <= !hit_ram && !hit_exit;
    end else if (any_rsp) begin
      busy_q <= 1'b0;
      decerr_q <= 1'b0;
    end
  end

  // --------------------
  // response steering
  // --------------------
  always_comb begin
    if (decerr_q) begin
      sel_rsp = '{rdata: '0, resp: RESP_DECERR};
    end else if (exit_rsp_valid_i) begin
      sel_rsp = exit_rsp_i;
    end else begin
      sel_rsp = ram_rsp_i;
    end
  end

  always_comb begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      rsp_valid_o[p] = any_rsp && (last_q == 1'(p));
      rsp_o[p] = sel_rsp;
    end
  end

  // one target is addressed at a time and never while another answers
  a_one_target : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0({ram_req_valid_o, exit_req_valid_o, ram_rsp_valid_i, exit_rsp_valid_i}))
    else $error("more than one target active");

  // every grant is answered on the next cycle
  a_grant_rsp : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    grant |=> any_rsp)
    else $error("grant without response one cycle later");

endmodule

// ==== ram_target.sv ====
`timescale 1ns/100ps

module ram_target (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              req_valid_i,
  input  bus_pkg::bus_req_t req_i,
  output logic              rsp_valid_o,
  output bus_pkg::bus_rsp_t rsp_o
);
  import bus_pkg::*;

  logic [DATA_W-1:0]     mem [RAM_WORDS];
  logic [WORD_IDX_W-1:0] idx;
  logic [DATA_W-1:0]     rdata_q;
  logic                  rsp_valid_q;

  assign idx = req_i.addr[BYTE_OFS_W +: WORD_IDX_W];  // word address, upper bits decoded away

  // --------------------
  // storage
  // --------------------
  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      if (req_i.write) begin
        for (int b = 0; b < STRB_W; b++) begin
          if (req_i.wstrb[b]) begin
            mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
          end
        end
      end
      rdata_q <= mem[idx];  // old word on writes, ignored by the port
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= req_valid_i;  // fixed one cycle latency
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o = '{rdata: rdata_q, resp: RESP_OKAY};

endmodule

// ==== exit_target.sv ====
`timescale 1ns/100ps

module exit_target (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              req_valid_i,
  input  bus_pkg::bus_req_t req_i,
  output logic              rsp_valid_o,
  output bus_pkg::bus_rsp_t rsp_o,
  output logic              exit_valid_o,
  output logic              exit_zero_o
);
  import bus_pkg::*;

  logic [DATA_W-1:0] code_q;
  logic [DATA_W-1:0] code_next;
  logic [DATA_W-1:0] rdata_q;
  logic              exit_valid_q;
  logic              exit_zero_q;
  logic              rsp_valid_q;

  // merge the strobed bytes into the stored code
  always_comb begin
    code_next = code_q;
    for (int b = 0; b < STRB_W; b++) begin
      if (req_i.wstrb[b]) begin
        code_next[8*b +: 8] = req_i.wdata[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      code_q <= '0;
      exit_valid_q <= 1'b0;
      exit_zero_q <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= req_valid_i;
      if (req_valid_i && req_i.write) begin
        code_q <= code_next;
        exit_valid_q <= 1'b1;  // sticky until reset
        exit_zero_q <= (code_next == '0);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      rdata_q <= code_q;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o = '{rdata: rdata_q, resp: RESP_OKAY};
  assign exit_valid_o = exit_valid_q;
  assign exit_zero_o = exit_zero_q;

endmodule

// ==== soc_bus_top.sv ====
`timescale 1ns/100ps

module soc_bus_top (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  // data master
  input  logic [bus_pkg::ADDR_W-1:0] data_awaddr_i,
  input  logic                       data_awvalid_i,
  output logic                       data_awready_o,
  input  logic [bus_pkg::DATA_W-1:0] data_wdata_i,
  input  logic [bus_pkg::STRB_W-1:0] data_wstrb_i,
  input  logic                       data_wvalid_i,
  output logic                       data_wready_o,
  output logic [1:0]                 data_bresp_o,
  output logic                       data_bvalid_o,
  input  logic                       data_bready_i,
  input  logic [bus_pkg::ADDR_W-1:0] data_araddr_i,
  input  logic                       data_arvalid_i,
  output logic                       data_arready_o,
  output logic [bus_pkg::DATA_W-1:0] data_rdata_o,
  output logic [1:0]                 data_rresp_o,
  output logic                       data_rvalid_o,
  input  logic                       data_rready_i,
  // instruction master
  input  logic [bus_pkg::ADDR_W-1:0] instr_awaddr_i,
  input  logic                       instr_awvalid_i,
  output logic                       instr_awready_o,
  input  logic [bus_pkg::DATA_W-1:0] instr_wdata_i,
  input  logic [bus_pkg::STRB_W-1:0] instr_wstrb_i,
  input  logic                       instr_wvalid_i,
  output logic                       instr_wready_o,
  output logic [1:0]                 instr_bresp_o,
  output logic                       instr_bvalid_o,
  input  logic                       instr_bready_i,
  input  logic [bus_pkg::ADDR_W-1:0] instr_araddr_i,
  input  logic                       instr_arvalid_i,
  output logic                       instr_arready_o,
  output logic [bus_pkg::DATA_W-1:0] instr_rdata_o,
  output logic [1:0]                 instr_rresp_o,
  output logic                       instr_rvalid_o,
  input  logic                       instr_rready_i,
  // end of simulation
  output logic                       exit_valid_o,
  output logic                       exit_zero_o
);
  import bus_pkg::*;

  logic [NUM_PORTS-1:0] port_req_valid;
  bus_req_t             port_req [NUM_PORTS];
  logic [NUM_PORTS-1:0] port_rsp_valid;
  bus_rsp_t             port_rsp [NUM_PORTS];
  logic                 ram_req_valid;
  logic                 exit_req_valid;
  bus_req_t             tgt_req;
  logic                 ram_rsp_valid;
  bus_rsp_t             ram_rsp;
  logic                 exit_rsp_valid;
  bus_rsp_t             exit_rsp;

  // --------------------
  // master ports
  // --------------------
  axil_port i_data_port (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .awaddr_i    (data_awaddr_i),
    .awvalid_i   (data_awvalid_i),
    .awready_o   (data_awready_o),
    .wdata_i     (data_wdata_i),
    .wstrb_i     (data_wstrb_i),
    .wvalid_i    (data_wvalid_i),
    .wready_o    (data_wready_o),
    .bresp_o     (data_bresp_o),
    .bvalid_o    (data_bvalid_o),
    .bready_i    (data_bready_i),
    .araddr_i    (data_araddr_i),
    .arvalid_i   (data_arvalid_i),
    .arready_o   (data_arready_o),
    .rdata_o     (data_rdata_o),
    .rresp_o     (data_rresp_o),
    .rvalid_o    (data_rvalid_o),
    .rready_i    (data_rready_i),
    .req_valid_o (port_req_valid[0]),
    .req_o       (port_req[0]),
    .rsp_valid_i (port_rsp_valid[0]),
    .rsp_i       (port_rsp[0])
  );

  axil_port i_instr_port (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .awaddr_i    (instr_awaddr_i),
    .awvalid_i   (instr_awvalid_i),
    .awready_o   (instr_awready_o),
    .wdata_i     (instr_wdata_i),
    .wstrb_i     (instr_wstrb_i),
    .wvalid_i    (instr_wvalid_i),
    .wready_o    (instr_wready_o),
    .bresp_o     (instr_bresp_o),
    .bvalid_o    (instr_bvalid_o),
    .bready_i    (instr_bready_i),
    .araddr_i    (instr_araddr_i),
    .arvalid_i   (instr_arvalid_i),
    .arready_o   (instr_arready_o),
    .rdata_o     (instr_rdata_o),
    .rresp_o     (instr_rresp_o),
    .rvalid_o    (instr_rvalid_o),
    .rready_i    (instr_rready_i),
    .req_valid_o (port_req_valid[1]),
    .req_o       (port_req[1]),
    .rsp_valid_i (port_rsp_valid[1]),
    .rsp_i       (port_rsp[1])
  );

  bus_arbiter i_arbiter (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .req_valid_i      (port_req_valid),
    .req_i            (port_req),
    .rsp_valid_o      (port_rsp_valid),
    .rsp_o            (port_rsp),
    .ram_req_valid_o  (ram_req_valid),
    .exit_req_valid_o (exit_req_valid),
    .tgt_req_o        (tgt_req),
    .ram_rsp_valid_i  (ram_rsp_valid),
    .ram_rsp_i        (ram_rsp),
    .exit_rsp_valid_i (exit_rsp_valid),
    .exit_rsp_i       (exit_rsp)
  );

  // --------------------
  // targets
  // --------------------
  ram_target i_ram (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_valid_i (ram_req_valid),
    .req_i       (tgt_req),
    .rsp_valid_o (ram_rsp_valid),
    .rsp_o       (ram_rsp)
  );

  exit_target i_exit (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .req_valid_i  (exit_req_valid),
    .req_i        (tgt_req),
    .rsp_valid_o  (exit_rsp_valid),
    .rsp_o        (exit_rsp),
    .exit_valid_o (exit_valid_o),
    .exit_zero_o  (exit_zero_o)
  );

endmodule

// ==== tb_soc_bus_tasks.svh ====
`ifndef TB_SOC_BUS_TASKS_SVH
`define TB_SOC_BUS_TASKS_SVH

  // --------------------
  // random numbers
  // --------------------
  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic next_rand_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic int rand_bits(input int n);
    int val;
    val = 0;
    for (int b = 0; b < n; b++) begin
      val = (val << 1) | int'(next_rand_bit());
    end
    return val;
  endfunction

  // bytewise merge, as a strobed write does to a stored word
  function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
                                                    input logic [DATA_W-1:0] new_word,
                                                    input logic [STRB_W-1:0] strb);
    logic [DATA_W-1:0] res;
    res = old_word;
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return res;
  endfunction

  task automatic check_value(input string what, input logic [DATA_W-1:0] expected,
                             input logic [DATA_W-1:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: expected %h, actual %h", what, expected, actual);
      err_count++;
    end
  endtask

  // --------------------
  // AXI4-Lite master side
  // --------------------
  task automatic axi_write(input logic p, input string name, input logic [ADDR_W-1:0] addr,
                           input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] strb,
                           output logic [1:0] resp);
    int   cycles;
    int   hold;
    logic aw_hs;
    logic w_hs;
    resp = 'x;
    @(negedge clk);
    awaddr[p] = addr;
    awvalid[p] = 1'b1;
    wdata[p] = data;
    wstrb[p] = strb;
    wvalid[p] = 1'b1;
    cycles = 0;
    while ((awvalid[p] || wvalid[p]) && cycles < WAIT_LIMIT) begin
      aw_hs = awvalid[p] && awready[p];  // ready comes from port state only
      w_hs = wvalid[p] && wready[p];
      @(negedge clk);
      if (aw_hs) begin
        awvalid[p] = 1'b0;
      end
      if (w_hs) begin
        wvalid[p] = 1'b0;
      end
      cycles++;
    end
    if (awvalid[p] || wvalid[p]) begin
      $display("timeout: %s, port %0d never accepted the write address or data", name, p);
      timed_out = 1'b1;
      return;
    end
    cycles = 0;
    while (!bvalid[p] && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (!bvalid[p]) begin
      $display("timeout: %s, port %0d gave no write response", name, p);
      timed_out = 1'b1;
      return;
    end
    resp = bresp[p];
    hold = rand_bits(2);  // master stalls the response
    repeat (hold) begin
      @(negedge clk);
      check_value({name, " bvalid held"}, 1, DATA_W'(bvalid[p]));
      check_value({name, " bresp held"}, DATA_W'(resp), DATA_W'(bresp[p]));
    end
    bready[p] = 1'b1;
    @(negedge clk);
    bready[p] = 1'b0;
  endtask

  task automatic axi_read(input logic p, input string name, input logic [ADDR_W-1:0] addr,
                          output logic [DATA_W-1:0] data, output logic [1:0] resp);
    int   cycles;
    int   hold;
    logic ar_hs;
    data = 'x;
    resp = 'x;
    @(negedge clk);
    araddr[p] = addr;
    arvalid[p] = 1'b1;
    cycles = 0;
    while (arvalid[p] && cycles < WAIT_LIMIT) begin
      ar_hs = arready[p];  // no write is offered on this port meanwhile
      @(negedge clk);
      if (ar_hs) begin
        arvalid[p] = 1'b0;
      end
      cycles++;
    end
    if (arvalid[p]) begin
      $display("timeout: %s, port %0d never accepted the read address", name, p);
      timed_out = 1'b1;
      return;
    end
    cycles = 0;
    while (!rvalid[p] && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (!rvalid[p]) begin
      $display("timeout: %s, port %0d gave no read data", name, p);
      timed_out = 1'b1;
      return;
    end
    data = rdata[p];
    resp = rresp[p];
    hold = rand_bits(2);
    repeat (hold) begin
      @(negedge clk);
      check_value({name, " rvalid held"}, 1, DATA_W'(rvalid[p]));
      check_value({name, " rdata held"}, data, rdata[p]);
      check_value({name, " rresp held"}, DATA_W'(resp), DATA_W'(rresp[p]));
    end
    rready[p] = 1'b1;
    @(negedge clk);
    rready[p] = 1'b0;
  endtask

`endif

// ==== tb_soc_bus.sv ====
`timescale 1ns/100ps

module tb_soc_bus;
  import bus_pkg::*;

  localparam int          WAIT_LIMIT = 64;  // cycles for any single wait
  localparam logic [31:0] LFSR_SEED = 32'h7b7fda55;

  // one transaction from the pattern file
  typedef struct packed {
    logic              instr;  // 1 for the instruction port
    logic              write;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic [DATA_W-1:0] exp_rdata;
    logic [1:0]        exp_resp;
  } pattern_t;

  logic              clk;
  logic              arst_n;
  logic [ADDR_W-1:0] awaddr [NUM_PORTS];
  logic              awvalid [NUM_PORTS];
  logic              awready [NUM_PORTS];
  logic [DATA_W-1:0] wdata [NUM_PORTS];
  logic [STRB_W-1:0] wstrb [NUM_PORTS];
  logic              wvalid [NUM_PORTS];
  logic              wready [NUM_PORTS];
  logic [1:0]        bresp [NUM_PORTS];
  logic              bvalid [NUM_PORTS];
  logic              bready [NUM_PORTS];
  logic [ADDR_W-1:0] araddr [NUM_PORTS];
  logic              arvalid [NUM_PORTS];
  logic              arready [NUM_PORTS];
  logic [DATA_W-1:0] rdata [NUM_PORTS];
  logic [1:0]        rresp [NUM_PORTS];
  logic              rvalid [NUM_PORTS];
  logic              rready [NUM_PORTS];
  logic              exit_valid;
  logic              exit_zero;

  logic [31:0]       lfsr_state;
  int                err_count;
  int                n_pass;
  int                n_fail;
  bit                timed_out;
  logic [DATA_W-1:0] exit_code;  // what the exit register should hold
  pattern_t          pats [$];
  string             pat_names [$];

  `include "tb_soc_bus_tasks.svh"

  soc_bus_top i_dut (
    .clk_i           (clk),
    .arst_n_i        (arst_n),
    .data_awaddr_i   (awaddr[0]),
    .data_awvalid_i  (awvalid[0]),
    .data_awready_o  (awready[0]),
    .data_wdata_i    (wdata[0]),
    .data_wstrb_i    (wstrb[0]),
    .data_wvalid_i   (wvalid[0]),
    .data_wready_o   (wready[0]),
    .data_bresp_o    (bresp[0]),
    .data_bvalid_o   (bvalid[0]),
    .data_bready_i   (bready[0]),
    .data_araddr_i   (araddr[0]),
    .data_arvalid_i  (arvalid[0]),
    .data_arready_o  (arready[0]),
    .data_rdata_o    (rdata[0]),
    .data_rresp_o    (rresp[0]),
    .data_rvalid_o   (rvalid[0]),
    .data_rready_i   (rready[0]),
    .instr_awaddr_i  (awaddr[1]),
    .instr_awvalid_i (awvalid[1]),
    .instr_awready_o (awready[1]),
    .instr_wdata_i   (wdata[1]),
    .instr_wstrb_i   (wstrb[1]),
    .instr_wvalid_i  (wvalid[1]),
    .instr_wready_o  (wready[1]),
    .instr_bresp_o   (bresp[1]),
    .instr_bvalid_o  (bvalid[1]),
    .instr_bready_i  (bready[1]),
    .instr_araddr_i  (araddr[1]),
    .instr_arvalid_i (arvalid[1]),
    .instr_arready_o (arready[1]),
    .instr_rdata_o   (rdata[1]),
    .instr_rresp_o   (rresp[1]),
    .instr_rvalid_o  (rvalid[1]),
    .instr_rready_i  (rready[1]),
    .exit_valid_o    (exit_valid),
    .exit_zero_o     (exit_zero)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  task automatic init_port(input logic p);
    awaddr[p] = '0;
    awvalid[p] = 1'b0;
    wdata[p] = '0;
    wstrb[p] = '0;
    wvalid[p] = 1'b0;
    bready[p] = 1'b0;
    araddr[p] = '0;
    arvalid[p] = 1'b0;
    rready[p] = 1'b0;
  endtask

  // a port leaves reset ready on AW, W and AR with no response pending
  task automatic verify_port_idle(input logic p);
    string tag;
    tag = $sformatf("reset_state port %0d", p);
    check_value({tag, " awready"}, 1, DATA_W'(awready[p]));
    check_value({tag, " wready"}, 1, DATA_W'(wready[p]));
    check_value({tag, " arready"}, 1, DATA_W'(arready[p]));
    check_value({tag, " bvalid"}, 0, DATA_W'(bvalid[p]));
    check_value({tag, " rvalid"}, 0, DATA_W'(rvalid[p]));
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (err_count == errs_before && !timed_out) begin
      $display("test %s: passed", name);
      n_pass++;
    end else begin
      $display("test %s: failed", name);
      n_fail++;
    end
  endtask

  task automatic run_pattern(input int k);
    pattern_t          pt;
    logic [DATA_W-1:0] data;
    logic [1:0]        resp;
    pt = pats[k];
    if (pt.write) begin
      axi_write(pt.instr, pat_names[k], pt.addr, pt.data, pt.strb, resp);
      if (timed_out) begin
        return;
      end
      check_value({pat_names[k], " bresp"}, DATA_W'(pt.exp_resp), DATA_W'(resp));
      if (pt.addr == EXIT_ADDR) begin
        exit_code = merge_bytes(exit_code, pt.data, pt.strb);
        check_value({pat_names[k], " exit_valid"}, 1, DATA_W'(exit_valid));
        check_value({pat_names[k], " exit_zero"}, DATA_W'(exit_code == '0), DATA_W'(exit_zero));
      end
    end else begin
      axi_read(pt.instr, pat_names[k], pt.addr, data, resp);
      if (timed_out) begin
        return;
      end
      check_value({pat_names[k], " rresp"}, DATA_W'(pt.exp_resp), DATA_W'(resp));
      check_value({pat_names[k], " rdata"}, pt.exp_rdata, data);
    end
  endtask

  initial begin
    string       line;
    string       name;
    string       port_s;
    string       op_s;
    logic [31:0] f_addr;
    logic [31:0] f_data;
    logic [31:0] f_strb;
    logic [31:0] f_rdata;
    logic [31:0] f_resp;
    pattern_t    pt;
    int          fd;
    int          n_fields;
    int          i;
    int          errs_before;
    bit          setup_ok;

    arst_n = 1'b0;
    init_port(1'b0);
    init_port(1'b1);
    lfsr_state = LFSR_SEED;
    err_count = 0;
    n_pass = 0;
    n_fail = 0;
    timed_out = 1'b0;
    exit_code = '0;
    setup_ok = 1'b1;

    // --------------------
    // pattern file
    // --------------------
    fd = $fopen("bus_patterns.txt", "r");
    if (fd == 0) begin
      $display("could not open the pattern file bus_patterns.txt");
      setup_ok = 1'b0;
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() < 2 || line.getc(0) == "#") begin
          continue;  // blank or comment
        end
        n_fields = $sscanf(line, "%s %s %s %h %h %h %h %h", name, port_s, op_s,
                           f_addr, f_data, f_strb, f_rdata, f_resp);
        if (n_fields != 8 || !(port_s == "data" || port_s == "instr") ||
            !(op_s == "wr" || op_s == "rd")) begin
          $display("pattern line could not be read: %s", line);
          setup_ok = 1'b0;
        end else begin
          pt.instr = (port_s == "instr");
          pt.write = (op_s == "wr");
          pt.addr = f_addr;
          pt.data = f_data;
          pt.strb = f_strb[STRB_W-1:0];
          pt.exp_rdata = f_rdata;
          pt.exp_resp = f_resp[1:0];
          pats.push_back(pt);
          pat_names.push_back(name);
        end
      end
      $fclose(fd);
    end

    repeat (4) @(negedge clk);
    arst_n = 1'b1;

    errs_before = err_count;
    check_value("reset_state exit_valid", 0, DATA_W'(exit_valid));
    check_value("reset_state exit_zero", 0, DATA_W'(exit_zero));
    verify_port_idle(1'b0);
    verify_port_idle(1'b1);
    report_test("reset_state", errs_before);

    // --------------------
    // run patterns with equal neighbours started in the same cycle
    // --------------------
    i = 0;
    while (setup_ok && i < pats.size() && !timed_out) begin
      errs_before = err_count;
      if (i + 1 < pats.size() && pat_names[i + 1] == pat_names[i]) begin
        fork
          run_pattern(i);
          run_pattern(i + 1);
        join
        report_test(pat_names[i], errs_before);
        i += 2;
      end else begin
        run_pattern(i);
        report_test(pat_names[i], errs_before);
        i += 1;
      end
    end

    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             n_pass + n_fail, n_pass, n_fail, err_count);
    if (setup_ok && pats.size() > 0 && !timed_out && n_fail == 0 && err_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== bus_patterns.txt ====
# name port(data/instr) op(wr/rd) addr data strb exp_rdata exp_resp, numbers in hex
# exp_rdata counts on reads only; neighbouring lines with one name start together
shared_wr      data  wr 00000100 cafef00d f 00000000 0
shared_rd_d    data  rd 00000100 00000000 0 cafef00d 0
shared_rd_i    instr rd 00000100 00000000 0 cafef00d 0
strb_wr_b1     data  wr 00000100 11223344 2 00000000 0
strb_rd_b1     instr rd 00000100 00000000 0 cafe330d 0
strb_wr_hi     instr wr 00000100 aabbccdd c 00000000 0
strb_rd_hi     data  rd 00000100 00000000 0 aabb330d 0
word0_wr       data  wr 00000000 01234567 f 00000000 0
decerr_wr      instr wr 00001000 deadbeef f 00000000 3
decerr_rd      data  rd 00002000 00000000 0 00000000 3
decerr_keep    instr rd 00000000 00000000 0 01234567 0
conc_wr        data  wr 00000200 a5a5a5a5 f 00000000 0
conc_wr        instr wr 00000204 5a5a5a5a f 00000000 0
conc_rd        data  rd 00000204 00000000 0 5a5a5a5a 0
conc_rd        instr rd 00000200 00000000 0 a5a5a5a5 0
conc_mix       instr wr 00000300 13579bdf f 00000000 0
conc_mix       data  rd 00000100 00000000 0 aabb330d 0
conc_mix_chk   data  rd 00000300 00000000 0 13579bdf 0
last_wr        instr wr 00000ffc ffffffff f 00000000 0
last_rd        data  rd 00000ffc 00000000 0 ffffffff 0
exit_rd_rst    data  rd 10000000 00000000 0 00000000 0
exit_wr_code   data  wr 10000000 0000002a f 00000000 0
exit_rd_code   instr rd 10000000 00000000 0 0000002a 0
exit_wr_zero   data  wr 10000000 00000000 f 00000000 0
exit_rd_zero   data  rd 10000000 00000000 0 00000000 0

// ==== sim.f ====
+incdir+.
bus_pkg.sv
axil_port.sv
bus_arbiter.sv
ram_target.sv
exit_target.sv
soc_bus_top.sv
tb_soc_bus.sv

// ==== Makefile ====
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only --timing --timescale 1ns/100ps
SIM_FLAGS  ?= --binary --timing --assert --timescale 1ns/100ps
TOP        ?= tb_soc_bus
FILELIST   ?= sim.f
LOG        ?= sim.log
PASS_MSG   := Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
